/* Makefile */
VERILATOR ?= verilator
TOP       ?= learning_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a pass line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+include
source/music_pkg.sv
source/learn_pkg.sv
source/song_rom.sv
source/key_matcher.sv
source/lesson_tracker.sv
source/buzzer.sv
source/learning_top.sv
verif/learning_sva.sv
verif/learning_tb.sv

/* include/song_sheets.svh */
// Rest entry and the Little Star and Ode to Joy song tables
`ifndef SONG_SHEETS_SVH
`define SONG_SHEETS_SVH

localparam sheet_entry_t REST_ENTRY = '0;

// Little Star, first phrase
localparam sheet_entry_t STAR_SHEET [1:SONG_NOTES] = '{
	'{'{PITCH_MID, KEY_DO},  {1'b0, KEY_DO},  LEN_1},
	'{'{PITCH_MID, KEY_DO},  {1'b0, KEY_DO},  LEN_1},
	'{'{PITCH_MID, KEY_SOL}, {1'b0, KEY_SOL}, LEN_1},
	'{'{PITCH_MID, KEY_SOL}, {1'b0, KEY_SOL}, LEN_1},
	'{'{PITCH_MID, KEY_LA},  {1'b0, KEY_LA},  LEN_1},
	'{'{PITCH_MID, KEY_LA},  {1'b0, KEY_LA},  LEN_1},
	'{'{PITCH_MID, KEY_SOL}, {1'b0, KEY_SOL}, LEN_1},
	REST_ENTRY,                                       // Breath
	'{'{PITCH_MID, KEY_FA},  {1'b0, KEY_FA},  LEN_1},
	'{'{PITCH_MID, KEY_FA},  {1'b0, KEY_FA},  LEN_1},
	'{'{PITCH_MID, KEY_MI},  {1'b0, KEY_MI},  LEN_1},
	'{'{PITCH_MID, KEY_MI},  {1'b0, KEY_MI},  LEN_1}
};

localparam sheet_entry_t JOY_SHEET [1:SONG_NOTES] = '{
	'{'{PITCH_MID, KEY_MI},  {1'b0, KEY_MI},  LEN_1},
	'{'{PITCH_MID, KEY_MI},  {1'b0, KEY_MI},  LEN_1},
	'{'{PITCH_MID, KEY_FA},  {1'b0, KEY_FA},  LEN_1},
	'{'{PITCH_MID, KEY_SOL}, {1'b0, KEY_SOL}, LEN_1},
	'{'{PITCH_MID, KEY_SOL}, {1'b0, KEY_SOL}, LEN_1},
	'{'{PITCH_MID, KEY_FA},  {1'b0, KEY_FA},  LEN_1},
	'{'{PITCH_MID, KEY_MI},  {1'b0, KEY_MI},  LEN_1},
	'{'{PITCH_MID, KEY_RE},  {1'b0, KEY_RE},  LEN_1},
	'{'{PITCH_MID, KEY_DO},  {1'b0, KEY_DO},  LEN_1},
	'{'{PITCH_MID, KEY_DO},  {1'b0, KEY_DO},  LEN_1},
	'{'{PITCH_MID, KEY_RE},  {1'b0, KEY_RE},  LEN_1},
	'{'{PITCH_MID, KEY_MI},  {1'b0, KEY_MI},  LEN_1}
};

`endif

/* source/buzzer.sv */
// Square-wave tone generator driven by the note code
`timescale 1ns/1ps

module buzzer
	import music_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  note_e note,
	output logic  speaker
);

	note_e             prev_note;
	note_e             look_note;
	logic [TONE_W-1:0] half;
	logic [TONE_W-1:0] count;
	logic              tone;

	// Keep the table index in range during a rest
	assign look_note = (note == NOTE_REST) ? NOTE_L1 : note;
	assign half      = TONE_HALF[look_note];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_note <= NOTE_REST;
			count     <= '0;
			tone      <= 1'b0;
		end else if (note != prev_note || note == NOTE_REST) begin
			prev_note <= note; // New note starts low
			count     <= '0;
			tone      <= 1'b0;
		end else if (count == half - 1'b1) begin
			count <= '0;
			tone  <= ~tone;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Silent in the same cycle the press goes wrong
	assign speaker = tone && (note != NOTE_REST);

endmodule

/* source/key_matcher.sv */
// Press against expected key compare and note code decode
`timescale 1ns/1ps

module key_matcher
	import music_pkg::*;
(
	input  logic    learn_en,
	input  played_t press,
	input  played_t expected,
	output logic    match,
	output note_e   note
);

	logic [2:0] degree; // 1 to 7, 0 when no single key

	assign match = (press == expected);

	always_comb begin
		case (press.key)
			KEY_DO:  degree = 3'd1;
			KEY_RE:  degree = 3'd2;
			KEY_MI:  degree = 3'd3;
			KEY_FA:  degree = 3'd4;
			KEY_SOL: degree = 3'd5;
			KEY_LA:  degree = 3'd6;
			KEY_SI:  degree = 3'd7;
			default: degree = 3'd0; // Rest or chord
		endcase
	end

	// Each range holds seven codes above the one below it
	always_comb begin
		note = NOTE_REST;
		if (learn_en && match && degree != 3'd0) begin
			case (press.pitch)
				PITCH_LOW:  note = note_e'({2'b00, degree});
				PITCH_MID:  note = note_e'(5'd7 + {2'b00, degree});
				PITCH_HIGH: note = note_e'(5'd14 + {2'b00, degree});
				default:    note = NOTE_REST;
			endcase
		end
	end

endmodule

/* source/learn_pkg.sv */
// Song select, lesson timing, score limits and song-sheet entry struct
package learn_pkg;

	import music_pkg::*;

	typedef enum logic {
		SONG_STAR = 1'b0,
		SONG_JOY  = 1'b1
	} song_e;

	localparam int NOTE_TICKS = 480; // Whole note hold
	localparam int HOLD_W     = 9;
	localparam int SONG_NOTES = 12;
	localparam int IDX_W      = 4;

	localparam int SCORE_W   = 16;
	localparam int SCORE_MAX = 60000;

	// Length divisor stored as a shift amount
	localparam logic [1:0] LEN_1 = 2'd0;
	localparam logic [1:0] LEN_2 = 2'd1;
	localparam logic [1:0] LEN_4 = 2'd2;

	typedef struct packed {
		played_t    expected;
		logic [7:0] led;
		logic [1:0] len_div;
	} sheet_entry_t;

endpackage

/* source/learning_top.sv */
// Learning mode top level with song ROM, key matcher, lesson tracker and buzzer
`timescale 1ns/1ps

module learning_top
	import music_pkg::*;
	import learn_pkg::*;
(
	input  logic               clk,
	input  logic               arst_n,
	input  logic               learn_en,
	input  song_e              song,
	input  played_t            press,
	output logic               speaker,
	output logic [7:0]         led,
	output pitch_e             pitch_ind,
	output logic               finished,
	output logic [SCORE_W-1:0] score
);

	logic [IDX_W-1:0] index;
	sheet_entry_t     entry;
	logic             match;
	note_e            note;

	song_rom u_song_rom (
		.song  (song),
		.index (index),
		.entry (entry)
	);

	key_matcher u_key_matcher (
		.learn_en (learn_en),
		.press    (press),
		.expected (entry.expected),
		.match    (match),
		.note     (note)
	);

	lesson_tracker u_lesson_tracker (
		.clk      (clk),
		.arst_n   (arst_n),
		.learn_en (learn_en),
		.song     (song),
		.match    (match),
		.len_div  (entry.len_div),
		.index    (index),
		.finished (finished),
		.score    (score)
	);

	buzzer u_buzzer (
		.clk     (clk),
		.arst_n  (arst_n),
		.note    (note),
		.speaker (speaker)
	);

	assign led       = entry.led;
	assign pitch_ind = entry.expected.pitch; // Range of the expected note

endmodule

/* source/lesson_tracker.sv */
// Note index, hold timer, finished flag and mistake score of a lesson
`timescale 1ns/1ps

module lesson_tracker
	import learn_pkg::*;
(
	input  logic               clk,
	input  logic               arst_n,
	input  logic               learn_en,
	input  song_e              song,
	input  logic               match,
	input  logic [1:0]         len_div,
	output logic [IDX_W-1:0]   index,
	output logic               finished,
	output logic [SCORE_W-1:0] score
);

	logic [HOLD_W-1:0] hold_cnt;
	logic [HOLD_W-1:0] hold_limit;
	song_e             last_song;
	logic              restart;
	logic              at_limit;

	assign hold_limit = HOLD_W'(NOTE_TICKS >> len_div);
	assign at_limit   = (hold_cnt == hold_limit);
	assign restart    = !learn_en || (song != last_song);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			index     <= '0;
			hold_cnt  <= '0;
			finished  <= 1'b0;
			score     <= '0;
			last_song <= SONG_STAR;
		end else begin
			last_song <= song;
			if (restart) begin
				index    <= '0;
				hold_cnt <= '0;
				finished <= 1'b0;
				score    <= '0;
			end else if (at_limit) begin
				hold_cnt <= '0; // Note passed, press ignored
				if (index == IDX_W'(SONG_NOTES)) begin
					index    <= IDX_W'(1); // Skip the lead-in on replay
					finished <= 1'b1;
				end else begin
					index <= index + 1'b1;
				end
			end else if (match) begin
				hold_cnt <= hold_cnt + 1'b1;
			end else begin
				hold_cnt <= '0;
				if (score <= SCORE_W'(SCORE_MAX)) begin
					score <= score + 1'b1;
				end
			end
		end
	end

endmodule

/* source/music_pkg.sv */
// Pitch ranges, key and note codes, played struct and tone half-period table
package music_pkg;

	// Range coding kept from the keyboard switches
	typedef enum logic [1:0] {
		PITCH_MID  = 2'b00,
		PITCH_LOW  = 2'b01,
		PITCH_HIGH = 2'b10
	} pitch_e;

	// One-hot scale degree, bit 0 is do
	typedef logic [6:0] key_t;

	localparam key_t KEY_DO  = 7'b000_0001;
	localparam key_t KEY_RE  = 7'b000_0010;
	localparam key_t KEY_MI  = 7'b000_0100;
	localparam key_t KEY_FA  = 7'b000_1000;
	localparam key_t KEY_SOL = 7'b001_0000;
	localparam key_t KEY_LA  = 7'b010_0000;
	localparam key_t KEY_SI  = 7'b100_0000;

	typedef struct packed {
		pitch_e pitch;
		key_t   key;
	} played_t; // All zero is a rest

	typedef enum logic [4:0] {
		NOTE_REST = 5'd0,
		NOTE_L1, NOTE_L2, NOTE_L3, NOTE_L4, NOTE_L5, NOTE_L6, NOTE_L7,
		NOTE_M1, NOTE_M2, NOTE_M3, NOTE_M4, NOTE_M5, NOTE_M6, NOTE_M7,
		NOTE_H1, NOTE_H2, NOTE_H3, NOTE_H4, NOTE_H5, NOTE_H6, NOTE_H7
	} note_e;

	localparam int TONE_W = 8;

	// Half period in clock cycles, indexed by note code
	localparam logic [TONE_W-1:0] TONE_HALF [1:21] = '{
		8'd160, // L1
		8'd150,
		8'd140,
		8'd132,
		8'd124,
		8'd116,
		8'd108,
		8'd102, // M1
		8'd96,
		8'd90,
		8'd84,
		8'd78,
		8'd73,
		8'd68,
		8'd64,  // H1
		8'd60,
		8'd56,
		8'd52,
		8'd48,
		8'd44,
		8'd40
	};

endpackage

/* source/song_rom.sv */
// Song-sheet lookup by song and note index
`timescale 1ns/1ps

module song_rom
	import music_pkg::*;
	import learn_pkg::*;
(
	input  song_e            song,
	input  logic [IDX_W-1:0] index,
	output sheet_entry_t     entry
);

	`include "song_sheets.svh"

	logic in_range;

	// Index 0 is the lead-in rest
	assign in_range = (index != '0) && (index <= IDX_W'(SONG_NOTES));

	always_comb begin
		entry = REST_ENTRY;
		if (in_range) begin
			case (song)
				SONG_STAR: entry = STAR_SHEET[index];
				SONG_JOY:  entry = JOY_SHEET[index];
				default:   entry = REST_ENTRY;
			endcase
		end
	end

endmodule

/* verif/learning_golden.txt */
// learn_en song pitch key cycles | led pitch_ind finished score tone_limit, all hex
// tone_limit 0 means speaker low for the whole hold, a row with 0 cycles ends the steps
0 0 0 00 004  00 0 0 0000 00  // Reset values, learn off
1 0 0 00 1E1  01 0 0 0000 00  // Little Star lead-in rest
1 0 0 01 1E1  01 0 0 0000 68  // Note 1 do
1 0 0 01 1E1  10 0 0 0000 68  // Note 2 do
1 0 0 10 1E1  10 0 0 0000 50  // Note 3 sol
1 0 0 10 1E1  20 0 0 0000 50  // Note 4 sol
1 0 0 20 1E1  20 0 0 0000 4B  // Note 5 la
1 0 0 20 1E1  10 0 0 0000 4B  // Note 6 la
1 0 0 10 1E1  00 0 0 0000 50  // Note 7 sol
1 0 0 00 1E1  08 0 0 0000 00  // Note 8 breath
1 0 0 08 1E1  08 0 0 0000 56  // Note 9 fa
1 0 0 08 1E1  04 0 0 0000 56  // Note 10 fa
1 0 0 04 1E1  04 0 0 0000 5C  // Note 11 mi
1 0 0 02 020  04 0 0 0020 00  // Wrong key re
1 0 2 04 010  04 0 0 0030 00  // Mi in the wrong range
1 0 0 04 1E1  01 0 1 0030 5C  // Note 12 mi, song done
1 1 0 00 001  00 0 0 0000 00  // Switch to Ode to Joy
1 1 0 00 1E1  04 0 0 0000 00  // Ode to Joy lead-in rest
1 1 0 04 1E1  04 0 0 0000 5C  // Note 1 mi
1 1 0 04 1E1  08 0 0 0000 5C  // Note 2 mi
1 1 0 08 1E1  10 0 0 0000 56  // Note 3 fa
1 1 0 10 1E1  10 0 0 0000 50  // Note 4 sol
1 1 0 10 1E1  08 0 0 0000 50  // Note 5 sol
1 1 0 08 1E1  04 0 0 0000 56  // Note 6 fa
1 1 0 04 1E1  02 0 0 0000 5C  // Note 7 mi
1 1 0 02 1E1  01 0 0 0000 62  // Note 8 re
1 1 0 01 1E1  01 0 0 0000 68  // Note 9 do
1 1 0 01 1E1  02 0 0 0000 68  // Note 10 do
1 1 0 02 1E1  04 0 0 0000 62  // Note 11 re
1 1 0 04 1E1  04 0 1 0000 5C  // Note 12 mi, song done
1 1 0 04 1E1  04 0 1 0000 5C  // Replay of note 1, finished holds
1 0 0 00 001  00 0 0 0000 00  // Back to Little Star clears the lesson
1 0 0 01 005  00 0 0 0005 00  // Do against the lead-in rest
0 0 0 01 002  00 0 0 0000 00  // Learn off clears the score
0 0 0 00 000  00 0 0 0000 00  // End of steps

/* verif/learning_sva.sv */
// Concurrent assertions on the lesson tracker and buzzer signals, with their bind
`timescale 1ns/1ps

module learning_sva
	import music_pkg::*;
	import learn_pkg::*;
(
	input logic               clk,
	input logic               arst_n,
	input logic               learn_en,
	input song_e              song,
	input logic               finished,
	input logic [SCORE_W-1:0] score,
	input note_e              note,
	input logic               speaker
);

	// No restart on this edge, so the score may only hold or grow
	score_no_drop: assert property (
		@(posedge clk) disable iff (!arst_n)
		(learn_en && song == $past(song)) |=> (score >= $past(score))
	) else $error("score dropped without a lesson restart");

	// A rest clears the tone register, so the next cycle starts silent
	rest_is_silent: assert property (
		@(posedge clk) disable iff (!arst_n)
		(note == NOTE_REST) |=> !speaker
	) else $error("speaker high in the cycle after a rest note");

	finished_sticky: assert property (
		@(posedge clk) disable iff (!arst_n)
		(finished && learn_en && song == $past(song)) |=> finished
	) else $error("finished cleared without a lesson restart");

endmodule

// Tracker and buzzer signals meet at the top level
bind learning_top learning_sva u_learning_sva (
	.clk      (clk),
	.arst_n   (arst_n),
	.learn_en (learn_en),
	.song     (song),
	.finished (finished),
	.score    (score),
	.note     (note),
	.speaker  (speaker)
);

/* verif/learning_tb.sv */
// Testbench for the learning mode top level, driven by the golden step file
`timescale 1ns/1ps

module learning_tb
	import music_pkg::*;
	import learn_pkg::*;
();

	localparam int    CLK_HALF     = 50;
	localparam int    RESET_CYCLES = 10;
	localparam int    DRIVE_DELAY  = 5;
	localparam int    CHECK_DELAY  = 2;
	localparam int    FIELDS       = 10; // Words per golden row
	localparam int    MAX_STEPS    = 64;
	localparam string GOLDEN_FILE  = "verif/learning_golden.txt";

	logic               clk;
	logic               arst_n;
	logic               learn_en;
	song_e              song;
	played_t            press;
	logic               speaker;
	logic [7:0]         led;
	pitch_e             pitch_ind;
	logic               finished;
	logic [SCORE_W-1:0] score;

	logic [15:0] gold_mem [0:FIELDS*MAX_STEPS-1];
	int          cycle_cnt;
	int          cycle_limit; // 0 until the golden file is read
	int          steps_run;
	logic        spk_last;

	learning_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.learn_en  (learn_en),
		.song      (song),
		.press     (press),
		.speaker   (speaker),
		.led       (led),
		.pitch_ind (pitch_ind),
		.finished  (finished),
		.score     (score)
	);

	always #CLK_HALF clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			stop_with_failure($sformatf("timeout after %0d cycles, the steps did not finish",
				cycle_cnt));
		end
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_field(input string name, input int got, input int want);
		assert (got == want) else begin
			stop_with_failure($sformatf("mismatch at time %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, got, want));
		end
	endtask

	// Tone limit 0 means the speaker must stay low for the whole hold
	task automatic hold_step(input int cycles, input int tone_limit);
		int toggled_at;
		int last_toggle;
		toggled_at  = 0;
		last_toggle = 0;
		for (int i = 1; i <= cycles; i++) begin
			@(posedge clk);
			#CHECK_DELAY;
			if (tone_limit == 0) begin
				check_field("speaker", int'(speaker), 0);
			end else if (speaker != spk_last && i < cycles) begin // Last edge may mute on a new key
				if (last_toggle != 0) begin
					check_field("speaker half period", i - last_toggle, tone_limit - 2);
				end else begin
					toggled_at = i;
				end
				last_toggle = i;
			end
			spk_last = speaker;
		end
		if (tone_limit != 0) begin
			assert (toggled_at != 0 && toggled_at <= tone_limit) else begin
				stop_with_failure($sformatf("speaker did not toggle within %0d cycles at time %0t",
					tone_limit, $time));
			end
		end
	endtask

	initial begin
		int base;
		int hold_sum;
		clk      = 1'b0;
		arst_n   = 1'b0;
		learn_en = 1'b0;
		song     = SONG_STAR;
		press    = '0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		steps_run   = 0;
		spk_last    = 1'b0;
		hold_sum    = 0;
		for (int a = 0; a < FIELDS*MAX_STEPS; a++) begin
			gold_mem[a] = '0;
		end
		$readmemh(GOLDEN_FILE, gold_mem);
		for (int s = 0; s < MAX_STEPS; s++) begin
			if (gold_mem[s*FIELDS + 4] == '0) break; // Zero cycles ends the steps
			hold_sum = hold_sum + int'(gold_mem[s*FIELDS + 4]);
		end
		cycle_limit = 2 * (hold_sum + RESET_CYCLES);

		repeat (RESET_CYCLES) @(posedge clk);
		#CHECK_DELAY;
		check_field("speaker", int'(speaker), 0); // Values held by reset
		check_field("led", int'(led), 0);
		check_field("finished", int'(finished), 0);
		check_field("score", int'(score), 0);
		#(DRIVE_DELAY - CHECK_DELAY);
		arst_n = 1'b1;

		for (int s = 0; s < MAX_STEPS; s++) begin
			base = s * FIELDS;
			if (gold_mem[base + 4] == '0) break;
			learn_en    = gold_mem[base][0];
			song        = song_e'(gold_mem[base + 1][0]);
			press.pitch = pitch_e'(gold_mem[base + 2][1:0]);
			press.key   = gold_mem[base + 3][6:0];
			hold_step(int'(gold_mem[base + 4]), int'(gold_mem[base + 9]));
			check_field("led", int'(led), int'(gold_mem[base + 5]));
			check_field("pitch_ind", int'(pitch_ind), int'(gold_mem[base + 6]));
			check_field("finished", int'(finished), int'(gold_mem[base + 7]));
			check_field("score", int'(score), int'(gold_mem[base + 8]));
			#(DRIVE_DELAY - CHECK_DELAY); // Back to the drive point
			steps_run = steps_run + 1;
		end

		if (steps_run > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			stop_with_failure("the golden file held no steps");
		end
	end

endmodule
